/* flist.f */
source/xbar_pkg.sv
source/master_capture.sv
source/slave_arbiter.sv
source/resp_id_fifo.sv
source/resp_steer.sv
source/crossbar.sv
tb/tb_clkgen.sv
tb/tb_crossbar.sv

/* tb/tb_crossbar.sv */
/*
 crossbar testbench: random masters and slave models around the DUT,
 concurrent assertions on decode, read return, single reads and fairness
*/
`timescale 1ns/1ns

module tb_crossbar;

    localparam int SEED = 82156;
    localparam int N_RAND = 40;
    localparam int N_HAMMER = 12;
    localparam int LIMIT_CYCLES = 200 * xbar_pkg::M_QTY * (N_RAND + N_HAMMER) + 1000;
    localparam xbar_pkg::data_t RD_XOR = 32'h5A5A_5A5A;

    logic                  clk;
    logic                  resetn;
    xbar_pkg::bus_req_t    master_req [xbar_pkg::M_QTY];
    xbar_pkg::master_rsp_t master_rsp [xbar_pkg::M_QTY];
    xbar_pkg::bus_req_t    slave_req [xbar_pkg::S_QTY];
    xbar_pkg::slave_rsp_t  slave_rsp [xbar_pkg::S_QTY];

    int   mismatches = 0;
    int   failures = 0;
    int   cycle = 0;
    int   masters_done = 0;
    logic started = 1'b0;
    logic hammer_on = 1'b0;

    // slave model: acked reads and the cycle of their ack
    xbar_pkg::addr_t rd_addr_q [xbar_pkg::S_QTY][$];
    int              rd_cyc_q [xbar_pkg::S_QTY][$];

    // scoreboard, updated at the falling edge
    xbar_pkg::bus_req_t         acked_q [xbar_pkg::S_QTY][xbar_pkg::M_QTY][$];
    xbar_pkg::bus_req_t         exp_slave [xbar_pkg::S_QTY];
    int                         acks [xbar_pkg::S_QTY];
    int                         accepts [xbar_pkg::S_QTY];
    logic [xbar_pkg::M_QTY-1:0] open_now = '0;
    logic [xbar_pkg::M_QTY-1:0] rd_open = '0;
    xbar_pkg::addr_t            last_rd_addr [xbar_pkg::M_QTY];
    xbar_pkg::data_t            exp_rdata [xbar_pkg::M_QTY];
    int                         ack_total = 0;
    int                         accept_total = 0;
    int                         rd_total = 0;
    int                         resp_total = 0;
    // last four slave 2 accepts during the hammer phase
    xbar_pkg::m_id_t            fair_hist [4];
    int                         fair_cnt = 0;

    tb_clkgen clkgen0 (
        .clk    (clk),
        .resetn (resetn)
    );

    crossbar #(
        .FIFO_DEPTH (8)
    ) dut0 (
        .clk        (clk),
        .resetn     (resetn),
        .master_req (master_req),
        .master_rsp (master_rsp),
        .slave_req  (slave_req),
        .slave_rsp  (slave_rsp)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // hold the request until ack is seen, return just after that edge
    task automatic drive_request(input int m, input xbar_pkg::bus_req_t rq);
        master_req[m] = rq;
        @(negedge clk);
        while (!master_rsp[m].ack) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic master_traffic(input int m, input int n, input bit hammer);
        xbar_pkg::bus_req_t rq;
        xbar_pkg::s_id_t    s;
        int                 idle;
        for (int i = 0; i < n; i++) begin
            s = hammer ? xbar_pkg::s_id_t'(2) : xbar_pkg::s_id_t'($urandom_range(3, 0));
            rq.req = 1'b1;
            rq.cmd = hammer ? 1'b0 : 1'($urandom_range(1, 0));
            // master index in bits [3:2]
            rq.addr = {s, 26'($urandom), 2'(m), 2'b00};
            rq.wdata = $urandom;
            drive_request(m, rq);
            idle = hammer ? 0 : $urandom_range(2, 0);
            if (idle > 0 || i == n - 1) begin
                master_req[m] = '0;
            end
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // all masters in parallel, back when every one has finished
    task automatic run_masters(input int n, input bit hammer);
        masters_done = 0;
        for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
            fork
                automatic int mi = m;
                automatic int cnt = n;
                automatic bit hm = hammer;
                begin
                    master_traffic(mi, cnt, hm);
                    masters_done++;
                end
            join_none
        end
        wait (masters_done == xbar_pkg::M_QTY);
    endtask

    task automatic slave_acker(input int s);
        int gap;
        forever begin
            @(posedge clk);
            #1;
            while (slave_req[s].req) begin
                gap = $urandom_range(3, 0);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                slave_rsp[s].ack = 1'b1;
                if (slave_req[s].cmd) begin
                    rd_addr_q[s].push_back(slave_req[s].addr);
                    rd_cyc_q[s].push_back(cycle);
                end
                @(posedge clk);
                #1;
                slave_rsp[s].ack = 1'b0;
            end
        end
    endtask

    // answers in order, only reads acked in an earlier cycle
    task automatic slave_responder(input int s);
        forever begin
            @(posedge clk);
            #1;
            slave_rsp[s].resp = 1'b0;
            if (rd_cyc_q[s].size() > 0 && rd_cyc_q[s][0] < cycle
                && $urandom_range(1, 0) == 1) begin
                slave_rsp[s].resp = 1'b1;
                slave_rsp[s].rdata = rd_addr_q[s].pop_front() ^ RD_XOR;
                void'(rd_cyc_q[s].pop_front());
            end
        end
    endtask

    function automatic int reads_left();
        int n;
        n = 0;
        for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
            n += rd_cyc_q[s].size();
        end
        return n;
    endfunction

    // every acked request reached its slave and every read was answered
    task automatic wait_drained();
        @(posedge clk);
        #1;
        while (accept_total != ack_total || reads_left() != 0) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_and_finish();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        int mi;
        int d;
        if (resetn) begin
            for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
                if (slave_req[s].req) begin
                    mi = int'(slave_req[s].addr[3:2]);
                    if (acked_q[s][mi].size() > 0) begin
                        exp_slave[s] = acked_q[s][mi][0];
                    end else begin
                        exp_slave[s] = '0;
                    end
                    if (slave_rsp[s].ack) begin
                        if (acked_q[s][mi].size() > 0) begin
                            void'(acked_q[s][mi].pop_front());
                        end
                        accepts[s]++;
                        accept_total++;
                        if (s == 2 && hammer_on) begin
                            fair_hist[3] = fair_hist[2];
                            fair_hist[2] = fair_hist[1];
                            fair_hist[1] = fair_hist[0];
                            fair_hist[0] = xbar_pkg::m_id_t'(mi);
                            fair_cnt++;
                        end
                    end
                end
            end
            for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
                rd_open[m] = open_now[m];
                exp_rdata[m] = last_rd_addr[m] ^ RD_XOR;
                if (master_rsp[m].resp) begin
                    open_now[m] = 1'b0;
                    resp_total++;
                end
                if (master_req[m].req && master_rsp[m].ack) begin
                    d = int'(master_req[m].addr[31:30]);
                    acked_q[d][m].push_back(master_req[m]);
                    acks[d]++;
                    ack_total++;
                    if (master_req[m].cmd) begin
                        open_now[m] = 1'b1;
                        last_rd_addr[m] = master_req[m].addr;
                        rd_total++;
                    end
                end
            end
        end
    end

    for (genvar s = 0; s < xbar_pkg::S_QTY; s++) begin : g_slave_chk
        a_quiet: assert property (@(posedge clk) disable iff (!resetn)
            !started |-> !slave_req[s].req)
            else begin
                mismatches++;
                $display("MISMATCH at %0t: slave_req[%0d].req expected 0, actual %0b",
                         $time, s, $sampled(slave_req[s].req));
            end
        a_decode: assert property (@(posedge clk) disable iff (!resetn)
            slave_req[s].req |-> slave_req[s].addr[31:30] == 2'(s))
            else begin
                mismatches++;
                $display("MISMATCH at %0t: slave_req[%0d].addr[31:30] expected %0d, actual %0d",
                         $time, s, s, $sampled(slave_req[s].addr[31:30]));
            end
        a_fields: assert property (@(posedge clk) disable iff (!resetn)
            slave_req[s].req |-> slave_req[s] == exp_slave[s])
            else begin
                mismatches++;
                $display("MISMATCH at %0t: slave_req[%0d] expected %h, actual %h",
                         $time, s, $sampled(exp_slave[s]), $sampled(slave_req[s]));
            end
    end

    for (genvar m = 0; m < xbar_pkg::M_QTY; m++) begin : g_master_chk
        a_quiet: assert property (@(posedge clk) disable iff (!resetn)
            !started |-> !master_rsp[m].resp)
            else begin
                mismatches++;
                $display("MISMATCH at %0t: master_rsp[%0d].resp expected 0, actual %0b",
                         $time, m, $sampled(master_rsp[m].resp));
            end
        a_resp_open: assert property (@(posedge clk) disable iff (!resetn)
            master_rsp[m].resp |-> rd_open[m])
            else begin
                failures++;
                $display("at %0t: master %0d got a response with no read open", $time, m);
            end
        a_rdata: assert property (@(posedge clk) disable iff (!resetn)
            master_rsp[m].resp |-> master_rsp[m].rdata == exp_rdata[m])
            else begin
                mismatches++;
                $display("MISMATCH at %0t: master_rsp[%0d].rdata expected %h, actual %h",
                         $time, m, $sampled(exp_rdata[m]), $sampled(master_rsp[m].rdata));
            end
        a_single_read: assert property (@(posedge clk) disable iff (!resetn)
            master_rsp[m].ack |-> !rd_open[m])
            else begin
                failures++;
                $display("at %0t: master %0d acked while its read was still open", $time, m);
            end
    end

    a_fair: assert property (@(posedge clk) disable iff (!resetn)
        fair_cnt >= 4 |-> fair_hist[0] != fair_hist[1] && fair_hist[0] != fair_hist[2]
            && fair_hist[0] != fair_hist[3] && fair_hist[1] != fair_hist[2]
            && fair_hist[1] != fair_hist[3] && fair_hist[2] != fair_hist[3])
        else begin
            failures++;
            $display("at %0t: four consecutive slave 2 accepts repeat a master", $time);
        end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        failures++;
        $display("at %0t: run timed out before all requests were served", $time);
        report_and_finish();
    end

    initial begin
        void'($urandom(SEED));
        for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
            master_req[m] = '0;
        end
        for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
            slave_rsp[s] = '0;
        end
        wait (resetn);
        repeat (3) @(posedge clk);
        #1;
        for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
            fork
                automatic int si = s;
                slave_acker(si);
                slave_responder(si);
            join_none
        end
        started = 1'b1;
        run_masters(N_RAND, 1'b0);
        wait_drained();
        // every master keeps a write held for slave 2
        fair_cnt = 0;
        hammer_on = 1'b1;
        run_masters(N_HAMMER, 1'b1);
        wait_drained();
        hammer_on = 1'b0;
        for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
            assert (accepts[s] == acks[s])
                else begin
                    mismatches++;
                    $display("MISMATCH at %0t: accepts[%0d] expected %0d, actual %0d",
                             $time, s, acks[s], accepts[s]);
                end
        end
        assert (resp_total == rd_total)
            else begin
                mismatches++;
                $display("MISMATCH at %0t: resp_total expected %0d, actual %0d",
                         $time, rd_total, resp_total);
            end
        report_and_finish();
    end

endmodule

/* tb/tb_clkgen.sv */
/*
 testbench clock and reset
 10 ns clock, reset held low for the first few cycles
*/
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int RESET_CYCLES = 4
)(
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // released just after an edge, like the other inputs
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b1;
    end

endmodule

/* source/crossbar.sv */
/*
 4x4 crossbar: request capture and per-slave arbitration, read id
 tracking per slave, and steering of responses back to the masters
*/
`timescale 1ns/1ns

module crossbar #(
    parameter int FIFO_DEPTH = 8
)(
    input  logic                  clk,
    input  logic                  resetn,
    input  xbar_pkg::bus_req_t    master_req [xbar_pkg::M_QTY],
    output xbar_pkg::master_rsp_t master_rsp [xbar_pkg::M_QTY],
    output xbar_pkg::bus_req_t    slave_req [xbar_pkg::S_QTY],
    input  xbar_pkg::slave_rsp_t  slave_rsp [xbar_pkg::S_QTY]
);

    logic [xbar_pkg::M_QTY-1:0]                      master_ack;
    logic [xbar_pkg::M_QTY-1:0]                      master_resp;
    xbar_pkg::data_t                                 master_rdata [xbar_pkg::M_QTY];
    xbar_pkg::held_req_t                             held [xbar_pkg::S_QTY][xbar_pkg::M_QTY];
    logic [xbar_pkg::S_QTY-1:0][xbar_pkg::M_QTY-1:0] take;
    logic [xbar_pkg::S_QTY-1:0]                      accept_read;
    xbar_pkg::m_id_t                                 accept_id [xbar_pkg::S_QTY];
    xbar_pkg::m_id_t                                 head_id [xbar_pkg::S_QTY];

    master_capture master_capture0 (
        .clk         (clk),
        .resetn      (resetn),
        .master_req  (master_req),
        .master_ack  (master_ack),
        .master_resp (master_resp),
        .held        (held),
        .take        (take)
    );

    for (genvar s = 0; s < xbar_pkg::S_QTY; s++) begin : g_slave

        slave_arbiter slave_arbiter0 (
            .clk         (clk),
            .resetn      (resetn),
            .held        (held[s]),
            .take        (take[s]),
            .slave_req   (slave_req[s]),
            .slave_ack   (slave_rsp[s].ack),
            .accept_read (accept_read[s]),
            .accept_id   (accept_id[s])
        );

        // one entry per read accepted, popped by the slave response
        resp_id_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) resp_id_fifo0 (
            .clk     (clk),
            .resetn  (resetn),
            .push    (accept_read[s]),
            .push_id (accept_id[s]),
            .pop     (slave_rsp[s].resp),
            .head_id (head_id[s])
        );

    end

    resp_steer resp_steer0 (
        .slave_rsp    (slave_rsp),
        .head_id      (head_id),
        .master_resp  (master_resp),
        .master_rdata (master_rdata)
    );

    for (genvar m = 0; m < xbar_pkg::M_QTY; m++) begin : g_master
        assign master_rsp[m] = '{ack:   master_ack[m],
                                 resp:  master_resp[m],
                                 rdata: master_rdata[m]};
    end

endmodule

/* source/resp_steer.sv */
/*
 response steering: sends each slave response and its read data
 to the master named at the head of that slave's id FIFO
*/
`timescale 1ns/1ns

module resp_steer (
    input  xbar_pkg::slave_rsp_t       slave_rsp [xbar_pkg::S_QTY],
    input  xbar_pkg::m_id_t            head_id [xbar_pkg::S_QTY],
    output logic [xbar_pkg::M_QTY-1:0] master_resp,
    output xbar_pkg::data_t            master_rdata [xbar_pkg::M_QTY]
);

    // hit[m][s]: slave s is answering master m
    logic [xbar_pkg::M_QTY-1:0][xbar_pkg::S_QTY-1:0] hit;

    always_comb begin
        for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
            master_rdata[m] = '0;
            for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
                hit[m][s] = slave_rsp[s].resp && (head_id[s] == xbar_pkg::m_id_t'(m));
                if (hit[m][s]) begin
                    master_rdata[m] = slave_rsp[s].rdata;
                end
            end
            master_resp[m] = |hit[m];
        end
    end

    // two sources for one master would mean two reads in flight
    always_comb begin
        for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
            a_single_src: assert final ($countones(hit[m]) <= 1);
        end
    end

endmodule

/* source/resp_id_fifo.sv */
/*
 response id FIFO: master ids of the reads one slave has accepted,
 in acceptance order, head visible without latency
*/
`timescale 1ns/1ns

module resp_id_fifo #(
    parameter int FIFO_DEPTH = 8
)(
    input  logic            clk,
    input  logic            resetn,
    input  logic            push,
    input  xbar_pkg::m_id_t push_id,
    input  logic            pop,
    output xbar_pkg::m_id_t head_id
);

    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    xbar_pkg::m_id_t      mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 full;
    logic                 empty;

    assign full = (count == CNT_WIDTH'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign head_id = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_id;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // a slave answers only reads it has accepted
    a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
        pop |-> !empty);

    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
        push && !pop |-> !full);

endmodule

/* source/slave_arbiter.sv */
/*
 slave arbiter: round-robin pick among the held requests for one slave,
 loaded into the request register that faces the slave
*/
`timescale 1ns/1ns

module slave_arbiter (
    input  logic                       clk,
    input  logic                       resetn,
    input  xbar_pkg::held_req_t        held [xbar_pkg::M_QTY],
    output logic [xbar_pkg::M_QTY-1:0] take,
    output xbar_pkg::bus_req_t         slave_req,
    input  logic                       slave_ack,
    output logic                       accept_read,
    output xbar_pkg::m_id_t            accept_id
);

    xbar_pkg::m_id_t              base;
    logic [xbar_pkg::M_QTY-1:0]   pending;
    logic [2*xbar_pkg::M_QTY-1:0] doubled;
    logic [xbar_pkg::M_QTY-1:0]   rotated;
    logic                         found;
    xbar_pkg::m_id_t              pick;
    logic                         slave_free;
    logic                         accept;

    logic                         req_q;
    xbar_pkg::addr_t              addr_q;
    logic                         cmd_q;
    xbar_pkg::data_t              wdata_q;

    // rotate so the base master sits at bit 0, then take the lowest
    always_comb begin
        for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
            pending[m] = held[m].valid;
        end
        doubled = {pending, pending} >> base;
        rotated = doubled[xbar_pkg::M_QTY-1:0];
        found = 1'b0;
        pick = base;
        for (int i = 0; i < xbar_pkg::M_QTY; i++) begin
            if (rotated[i] && !found) begin
                found = 1'b1;
                pick = xbar_pkg::m_id_t'((int'(base) + i) % xbar_pkg::M_QTY);
            end
        end
    end

    assign slave_free = ~req_q | slave_ack;
    assign accept = slave_free & found;

    always_comb begin
        for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
            take[m] = accept & (pick == xbar_pkg::m_id_t'(m));
        end
    end

    assign accept_read = accept & held[pick].cmd;
    assign accept_id = pick;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_q <= 1'b0;
            base <= '0;
        end else if (accept) begin
            req_q <= 1'b1;
            if (base == xbar_pkg::m_id_t'(xbar_pkg::M_QTY-1)) begin
                base <= '0;
            end else begin
                base <= base + 1'b1;
            end
        end else if (slave_ack) begin
            req_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= held[pick].addr;
            cmd_q   <= held[pick].cmd;
            wdata_q <= held[pick].wdata;
        end
    end

    assign slave_req = '{req: req_q, addr: addr_q, cmd: cmd_q, wdata: wdata_q};

    // at most one slot emptied, and only a filled one
    a_take_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(take) && ((take & ~pending) == '0));

    // request toward the slave holds until acked
    a_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        slave_req.req && !slave_ack |=> slave_req.req && $stable(slave_req));

endmodule

/* source/master_capture.sv */
/*
 master capture: acks masters, decodes the target slave from the address
 and parks each request in a per-slave holding slot
*/
`timescale 1ns/1ns

module master_capture (
    input  logic                                            clk,
    input  logic                                            resetn,
    input  xbar_pkg::bus_req_t                              master_req [xbar_pkg::M_QTY],
    output logic [xbar_pkg::M_QTY-1:0]                      master_ack,
    input  logic [xbar_pkg::M_QTY-1:0]                      master_resp,
    output xbar_pkg::held_req_t                             held [xbar_pkg::S_QTY][xbar_pkg::M_QTY],
    input  logic [xbar_pkg::S_QTY-1:0][xbar_pkg::M_QTY-1:0] take
);

    xbar_pkg::s_id_t                                 dest [xbar_pkg::M_QTY];
    logic [xbar_pkg::S_QTY-1:0][xbar_pkg::M_QTY-1:0] held_valid;
    xbar_pkg::addr_t                                 held_addr [xbar_pkg::S_QTY][xbar_pkg::M_QTY];
    logic                                            held_cmd [xbar_pkg::S_QTY][xbar_pkg::M_QTY];
    xbar_pkg::data_t                                 held_wdata [xbar_pkg::S_QTY][xbar_pkg::M_QTY];
    // one read in flight per master
    logic [xbar_pkg::M_QTY-1:0]                      rd_pending;

    // decode and ack
    always_comb begin
        for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
            dest[m] = master_req[m].addr[xbar_pkg::ADDR_WIDTH-1 -: $bits(xbar_pkg::s_id_t)];
            // slot must be empty or emptied by the arbiter this cycle
            master_ack[m] = master_req[m].req & ~rd_pending[m]
                          & (~held_valid[dest[m]][m] | take[dest[m]][m]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            held_valid <= '0;
        end else begin
            for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
                for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
                    if (master_ack[m] && dest[m] == xbar_pkg::s_id_t'(s)) begin
                        held_valid[s][m] <= 1'b1;
                    end else if (take[s][m]) begin
                        held_valid[s][m] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
            for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
                if (master_ack[m] && dest[m] == xbar_pkg::s_id_t'(s)) begin
                    held_addr[s][m]  <= master_req[m].addr;
                    held_cmd[s][m]   <= master_req[m].cmd;
                    held_wdata[s][m] <= master_req[m].wdata;
                end
            end
        end
    end

    // set on read ack, cleared by the steered response
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_pending <= '0;
        end else begin
            for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
                if (master_ack[m] && master_req[m].cmd) begin
                    rd_pending[m] <= 1'b1;
                end else if (master_resp[m]) begin
                    rd_pending[m] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < xbar_pkg::S_QTY; s++) begin
            for (int m = 0; m < xbar_pkg::M_QTY; m++) begin
                held[s][m] = '{valid: held_valid[s][m],
                               addr:  held_addr[s][m],
                               cmd:   held_cmd[s][m],
                               wdata: held_wdata[s][m]};
            end
        end
    end

    for (genvar m = 0; m < xbar_pkg::M_QTY; m++) begin : g_chk
        // no further ack until the read comes back
        a_one_read: assert property (@(posedge clk) disable iff (!resetn)
            master_ack[m] && master_req[m].cmd |=> !master_ack[m] until_with master_resp[m]);
    end

endmodule

/* source/xbar_pkg.sv */
/*
 crossbar package
 counts, bus widths and the packed structs that travel on the ports
*/
package xbar_pkg;

    localparam int M_QTY = 4;
    localparam int S_QTY = 4;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [$clog2(M_QTY)-1:0] m_id_t;
    // slave index sits in the top address bits
    typedef logic [$clog2(S_QTY)-1:0] s_id_t;

    // master to crossbar and crossbar to slave, cmd 1 = read
    typedef struct packed {
        logic  req;
        addr_t addr;
        logic  cmd;
        data_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic  ack;
        logic  resp;
        data_t rdata;
    } master_rsp_t;

    typedef struct packed {
        logic  ack;
        logic  resp;
        data_t rdata;
    } slave_rsp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        logic  cmd;
        data_t wdata;
    } held_req_t;

endpackage
